/* common/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	// one serial character, 8N1
	typedef logic [7:0] byte_t;

	// bit phase, same encoding for receiver and transmitter
	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} uart_state_e;

endpackage

`default_nettype wire

/* common/frame_pkg.sv */
`default_nettype none

package frame_pkg;

	//////////////////////////////////////////////////////////////////////
	// frame layout
	//////////////////////////////////////////////////////////////////////

	localparam int magic_len = 4;

	localparam logic [31:0] setpoint_magic = 32'hD0D0D0D0;
	localparam logic [31:0] status_request_magic = 32'h1CE1CEBB;
	localparam logic [31:0] status_magic = 32'h1CEB00DA;

	// full lengths, magic and crc included
	localparam int setpoint_len = 11;
	localparam int status_request_len = 7;
	localparam int status_len = 21;

	typedef logic [15:0] crc_t;

	localparam crc_t crc_init = 16'hFFFF;
	// x^16 + x^15 + x^2 + 1
	localparam crc_t crc_poly = 16'h8005;

	// frame currently being collected
	typedef enum logic [1:0] {
		kind_none,
		kind_setpoint,
		kind_status_request
	} frame_kind_e;

	//////////////////////////////////////////////////////////////////////
	// crc16, one byte per call, msb first, no reflection
	//////////////////////////////////////////////////////////////////////

	function automatic crc_t crc16_byte(crc_t crc, logic [7:0] data);
		crc_t c;
		logic fb;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			fb = c[15] ^ data[i];
			c = {c[14:0], 1'b0};
			if (fb)
				c = c ^ crc_poly;
		end
		return c;
	endfunction

endpackage

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int clks_per_bit = 434
) (
	input logic CLK,
	input logic reset,
	input logic rx,
	output logic rx_valid,
	output uart_pkg::byte_t rx_data
);
	import uart_pkg::*;

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
	localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);

	logic rx_meta;
	logic rx_sync;
	uart_state_e state;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0] bit_idx;
	byte_t shreg;

	// line idles high
	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				st_idle: begin
					clk_cnt <= '0;
					if (!rx_sync)
						state <= st_start;
				end
				// glitch filter: start bit must still be low half a bit later
				st_start: begin
					if (clk_cnt == half_cnt) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? st_idle : st_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				st_data: begin
					if (clk_cnt == last_cnt) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= st_stop;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				st_stop: begin
					if (clk_cnt == last_cnt) begin
						clk_cnt <= '0;
						state <= st_idle;
						// framing error drops the byte
						rx_valid <= rx_sync;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge CLK) begin
		if (state == st_data && clk_cnt == last_cnt)
			shreg <= {rx_sync, shreg[7:1]};
		if (state == st_stop && clk_cnt == last_cnt && rx_sync)
			rx_data <= shreg;
	end

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int clks_per_bit = 434
) (
	input logic CLK,
	input logic reset,
	input logic start,
	input uart_pkg::byte_t data,
	output logic busy,
	output logic tx,
	output logic tx_enable
);
	import uart_pkg::*;

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

	uart_state_e state;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0] bit_idx;
	byte_t shreg;

	assign busy = (state != st_idle);
	// transceiver driver on for the whole character
	assign tx_enable = busy;

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx <= 1'b1;
		end else begin
			case (state)
				st_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (start) begin
						state <= st_start;
						tx <= 1'b0;
					end
				end
				st_start: begin
					if (clk_cnt == last_cnt) begin
						clk_cnt <= '0;
						state <= st_data;
						tx <= shreg[0];
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				st_data: begin
					if (clk_cnt == last_cnt) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= st_stop;
							tx <= 1'b1;
						end else begin
							// shreg shifts on this same edge
							tx <= shreg[1];
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				st_stop: begin
					if (clk_cnt == last_cnt) begin
						clk_cnt <= '0;
						state <= st_idle;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == st_idle && start)
			shreg <= data;
		else if (state == st_data && clk_cnt == last_cnt)
			shreg <= {1'b0, shreg[7:1]};
	end

	// the sender must wait for the previous character to finish
	a_start_when_idle: assert property (@(posedge CLK) disable iff (reset)
		start |-> !busy)
		else $error("uart_tx: start while busy");

endmodule

`default_nettype wire

/* verilog/frame_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_receiver (
	input logic CLK,
	input logic reset,
	input logic rx_valid,
	input uart_pkg::byte_t rx_data,
	output logic signed [31:0] setpoint,
	output logic status_request
);
	import frame_pkg::*;
	import uart_pkg::*;

	frame_kind_e kind;
	logic [4:0] count;
	logic [4:0] rem_len;
	crc_t crc;
	byte_t crc_hi;
	logic [31:0] window;
	logic [31:0] next_window;
	logic [31:0] sp_buf;
	logic in_body;
	logic at_crc_hi;
	logic at_last;

	assign next_window = {window[23:0], rx_data};

	// bytes still to come once the magic is seen
	always_comb begin
		if (kind == kind_setpoint)
			rem_len = 5'(setpoint_len - magic_len);
		else
			rem_len = 5'(status_request_len - magic_len);
	end

	assign in_body = (count < rem_len - 5'd2);
	assign at_crc_hi = (count == rem_len - 5'd2);
	assign at_last = (count == rem_len - 5'd1);

	//////////////////////////////////////////////////////////////////////
	// magic search and frame collection
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			kind <= kind_none;
			count <= '0;
			crc <= crc_init;
			window <= '0;
			setpoint <= '0;
			status_request <= 1'b0;
		end else begin
			status_request <= 1'b0;
			if (rx_valid) begin
				window <= next_window;
				if (kind == kind_none) begin
					count <= '0;
					crc <= crc_init;
					if (next_window == setpoint_magic)
						kind <= kind_setpoint;
					else if (next_window == status_request_magic)
						kind <= kind_status_request;
				end else begin
					count <= count + 5'd1;
					if (in_body)
						crc <= crc16_byte(crc, rx_data);
					if (at_last) begin
						kind <= kind_none;
						// crc is sent high byte first
						if ({crc_hi, rx_data} == crc) begin
							if (kind == kind_setpoint)
								setpoint <= sp_buf;
							else
								status_request <= 1'b1;
						end
					end
				end
			end
		end
	end

	// last four body bytes are the setpoint, the id drops out the top
	always_ff @(posedge CLK) begin
		if (rx_valid && kind != kind_none) begin
			if (in_body)
				sp_buf <= {sp_buf[23:0], rx_data};
			if (at_crc_hi)
				crc_hi <= rx_data;
		end
	end

	a_count_in_frame: assert property (@(posedge CLK) disable iff (reset)
		(kind != kind_none) |-> (count < rem_len))
		else $error("frame_receiver: byte count past end of frame");

endmodule

`default_nettype wire

/* verilog/status_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module status_sender (
	input logic CLK,
	input logic reset,
	input logic status_request,
	input uart_pkg::byte_t id,
	input logic signed [31:0] position,
	input logic signed [31:0] velocity,
	input logic signed [31:0] displacement,
	input logic [15:0] current,
	input logic busy,
	output logic start,
	output uart_pkg::byte_t data
);
	import frame_pkg::*;

	// id, position, velocity, displacement, current
	localparam int body_bits = (status_len - magic_len - 2) * 8;

	logic sending;
	logic [4:0] idx;
	crc_t crc;
	logic [body_bits-1:0] body_q;
	logic in_body;

	assign in_body = (idx >= 5'(magic_len)) && (idx < 5'(status_len - 2));

	// reply byte for the current index
	always_comb begin
		if (idx < 5'(magic_len))
			data = status_magic[8 * (magic_len - 1 - idx[1:0]) +: 8];
		else if (in_body)
			data = body_q[body_bits-1 -: 8];
		else if (idx == 5'(status_len - 2))
			data = crc[15:8];
		else
			data = crc[7:0];
	end

	//////////////////////////////////////////////////////////////////////
	// byte sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			sending <= 1'b0;
			idx <= '0;
			crc <= crc_init;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (!sending) begin
				// requests during a reply are dropped here
				if (status_request) begin
					sending <= 1'b1;
					idx <= '0;
					crc <= crc_init;
				end
			end else if (start) begin
				// transmitter has taken the byte
				idx <= idx + 5'd1;
				if (in_body)
					crc <= crc16_byte(crc, data);
			end else if (!busy) begin
				if (idx == 5'(status_len))
					sending <= 1'b0;
				else
					start <= 1'b1;
			end
		end
	end

	// telemetry frozen at request time, shifted out msb first
	always_ff @(posedge CLK) begin
		if (!sending && status_request)
			body_q <= {id, position, velocity, displacement, current};
		else if (start && in_body)
			body_q <= {body_q[body_bits-9:0], 8'h00};
	end

	a_index_in_reply: assert property (@(posedge CLK) disable iff (reset)
		start |-> (idx < 5'(status_len)))
		else $error("status_sender: start past end of reply");

endmodule

`default_nettype wire

/* verilog/motor_coms.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_coms #(
	parameter int clks_per_bit = 434
) (
	input logic CLK,
	input logic reset,
	input logic rx,
	output logic tx,
	output logic tx_enable,
	input uart_pkg::byte_t id,
	input logic signed [31:0] position,
	input logic signed [31:0] velocity,
	input logic signed [31:0] displacement,
	input logic [15:0] current,
	output logic signed [31:0] setpoint
);
	import uart_pkg::*;

	logic rx_valid;
	byte_t rx_data;
	logic status_request;
	logic tx_start;
	byte_t tx_data;
	logic tx_busy;

	//////////////////////////////////////////////////////////////////////
	// command path
	//////////////////////////////////////////////////////////////////////

	uart_rx #(
		.clks_per_bit(clks_per_bit)
	) rx0 (
		.CLK(CLK),
		.reset(reset),
		.rx(rx),
		.rx_valid(rx_valid),
		.rx_data(rx_data)
	);

	frame_receiver frame_rx0 (
		.CLK(CLK),
		.reset(reset),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.setpoint(setpoint),
		.status_request(status_request)
	);

	//////////////////////////////////////////////////////////////////////
	// status reply path, rs-485 side
	//////////////////////////////////////////////////////////////////////

	status_sender sender0 (
		.CLK(CLK),
		.reset(reset),
		.status_request(status_request),
		.id(id),
		.position(position),
		.velocity(velocity),
		.displacement(displacement),
		.current(current),
		.busy(tx_busy),
		.start(tx_start),
		.data(tx_data)
	);

	uart_tx #(
		.clks_per_bit(clks_per_bit)
	) tx0 (
		.CLK(CLK),
		.reset(reset),
		.start(tx_start),
		.data(tx_data),
		.busy(tx_busy),
		.tx(tx),
		.tx_enable(tx_enable)
	);

endmodule

`default_nettype wire

/* verification/motor_coms_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_coms_tb;
	import uart_pkg::*;

	localparam int cpb = 8;
	localparam int byte_cycles = 10 * cpb;
	localparam int reply_len = 21;
	localparam int timeout_cycles = 30 * byte_cycles;

	logic CLK;
	logic reset;
	logic rx;
	logic tx;
	logic tx_enable;
	byte_t id;
	logic signed [31:0] position;
	logic signed [31:0] velocity;
	logic signed [31:0] displacement;
	logic [15:0] current;
	logic signed [31:0] setpoint;

	logic [31:0] lcg_state = 32'h74f94696;
	logic line_used = 1'b0;
	logic tx_in_byte = 1'b0;
	byte_t tx_bytes[$];
	int checks = 0;
	int mismatches = 0;
	int other_errors = 0;

	motor_coms #(
		.clks_per_bit(cpb)
	) dut0 (
		.CLK(CLK),
		.reset(reset),
		.rx(rx),
		.tx(tx),
		.tx_enable(tx_enable),
		.id(id),
		.position(position),
		.velocity(velocity),
		.displacement(displacement),
		.current(current),
		.setpoint(setpoint)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// crc16 poly 8005, init ffff, msb first, no reflection, no final xor
	function automatic logic [15:0] crc_of(input byte_t bytes[$]);
		logic [15:0] c;
		c = 16'hFFFF;
		foreach (bytes[i]) begin
			c = c ^ {bytes[i], 8'h00};
			for (int k = 0; k < 8; k++)
				c = c[15] ? ({c[14:0], 1'b0} ^ 16'h8005) : {c[14:0], 1'b0};
		end
		return c;
	endfunction

	task automatic push_be(ref byte_t q[$], input logic [31:0] v, input int n);
		for (int i = n - 1; i >= 0; i--)
			q.push_back(v[8 * i +: 8]);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		a_value: assert (expected === actual)
		else begin
			mismatches++;
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge CLK);
			#5;
		end
	endtask

	// one bit on rx, entered 5 ns after a rising edge
	task automatic send_bit(input logic v);
		rx = v;
		idle_cycles(cpb);
	endtask

	task automatic send_byte(input byte_t b);
		line_used = 1'b1;
		send_bit(1'b0);
		for (int i = 0; i < 8; i++)
			send_bit(b[i]);
		send_bit(1'b1);
	endtask

	task automatic send_frame(input logic [31:0] magic, input byte_t body[$],
		input logic [15:0] crc_flip);
		byte_t frame[$];
		logic [15:0] crc;
		crc = crc_of(body) ^ crc_flip;
		push_be(frame, magic, 4);
		foreach (body[i])
			frame.push_back(body[i]);
		push_be(frame, {16'h0, crc}, 2);
		foreach (frame[i])
			send_byte(frame[i]);
	endtask

	task automatic wait_tx_count(input int n, input string what);
		int t;
		t = 0;
		while (tx_bytes.size() < n && t < timeout_cycles) begin
			@(posedge CLK);
			#5;
			t++;
		end
		if (tx_bytes.size() < n) begin
			other_errors++;
			$display("timeout in %s: only %0d of %0d bytes on tx", what, tx_bytes.size(), n);
		end
	endtask

	task automatic wait_tx_enable(input logic level, input string what);
		int t;
		t = 0;
		while (tx_enable !== level && t < timeout_cycles) begin
			@(posedge CLK);
			#5;
			t++;
		end
		if (tx_enable !== level) begin
			other_errors++;
			$display("timeout in %s: tx_enable never went to %b", what, level);
		end
	endtask

	task automatic new_telemetry();
		logic [31:0] r;
		r = next_random();
		id = r[7:0];
		position = next_random();
		velocity = next_random();
		displacement = next_random();
		r = next_random();
		current = r[15:0];
	endtask

	// expected reply built from the telemetry inputs, then the queue is cleared
	task automatic check_reply(input string name);
		byte_t body[$];
		byte_t expected[$];
		logic [15:0] crc;
		push_be(body, {24'h0, id}, 1);
		push_be(body, position, 4);
		push_be(body, velocity, 4);
		push_be(body, displacement, 4);
		push_be(body, {16'h0, current}, 2);
		crc = crc_of(body);
		push_be(expected, 32'h1CEB00DA, 4);
		foreach (body[i])
			expected.push_back(body[i]);
		push_be(expected, {16'h0, crc}, 2);
		check_value({name, " length"}, reply_len, tx_bytes.size());
		for (int i = 0; i < expected.size() && i < tx_bytes.size(); i++)
			check_value($sformatf("%s byte %0d", name, i), {24'h0, expected[i]},
				{24'h0, tx_bytes[i]});
		tx_bytes.delete();
	endtask

	//////////////////////////////////////////////////////////////////////
	// tx monitor, sampled on the falling edge
	//////////////////////////////////////////////////////////////////////

	initial begin : tx_monitor
		byte_t b;
		logic stop_bit;
		forever begin
			@(negedge CLK);
			if (!reset && tx === 1'b0) begin
				tx_in_byte = 1'b1;
				repeat (cpb / 2) @(negedge CLK);
				for (int i = 0; i < 8; i++) begin
					repeat (cpb) @(negedge CLK);
					b[i] = tx;
				end
				repeat (cpb) @(negedge CLK);
				stop_bit = tx;
				tx_in_byte = 1'b0;
				if (stop_bit === 1'b1) begin
					tx_bytes.push_back(b);
				end else begin
					other_errors++;
					$display("tx byte had a low stop bit");
				end
			end
		end
	end

	a_quiet_after_reset: assert property (@(posedge CLK) disable iff (reset)
		!line_used |-> (tx && !tx_enable && setpoint == 32'sd0))
		else begin
			other_errors++;
			$display("tx, tx_enable or setpoint moved before any frame was sent");
		end

	a_enable_during_byte: assert property (@(posedge CLK) disable iff (reset)
		tx_in_byte |-> tx_enable)
		else begin
			other_errors++;
			$display("tx_enable low while a reply byte was on tx");
		end

	// driver off means the line rests high
	a_idle_line_high: assert property (@(posedge CLK) disable iff (reset)
		!tx_enable |-> tx)
		else begin
			other_errors++;
			$display("tx low while tx_enable was low");
		end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		byte_t body[$];
		logic [31:0] r;
		logic [31:0] sp_val;
		int n_garbage;
		rx = 1'b1;
		reset = 1'b1;
		id = '0;
		position = '0;
		velocity = '0;
		displacement = '0;
		current = '0;
		repeat (10) @(posedge CLK);
		#5;
		reset = 1'b0;
		idle_cycles(4 * byte_cycles);
		check_value("setpoint after reset", 32'h0, setpoint);

		// setpoint frames behind random garbage, kept below 0x80 so no magic forms
		sp_val = '0;
		for (int n = 0; n < 4; n++) begin
			r = next_random();
			n_garbage = int'(r[1:0]) + 1;
			for (int g = 0; g < n_garbage; g++) begin
				r = next_random();
				send_byte(r[7:0] & 8'h7F);
			end
			sp_val = next_random();
			r = next_random();
			body.delete();
			push_be(body, {24'h0, r[7:0]}, 1);
			push_be(body, sp_val, 4);
			send_frame(32'hD0D0D0D0, body, 16'h0);
			idle_cycles(2);
			check_value($sformatf("setpoint frame %0d", n), sp_val, setpoint);
		end

		// flipped crc bit
		body.delete();
		push_be(body, 32'h5A, 1);
		push_be(body, next_random(), 4);
		send_frame(32'hD0D0D0D0, body, 16'h0100);
		idle_cycles(3 * byte_cycles);
		check_value("setpoint after bad crc", sp_val, setpoint);
		check_value("tx bytes after bad setpoint", 32'h0, tx_bytes.size());

		// one good status request
		new_telemetry();
		body.delete();
		push_be(body, {24'h0, id}, 1);
		send_frame(32'h1CE1CEBB, body, 16'h0);
		wait_tx_count(reply_len, "status reply");
		wait_tx_enable(1'b0, "status reply end");
		idle_cycles(3 * byte_cycles);
		check_reply("status reply");
		check_value("tx_enable after reply", 32'h0, {31'h0, tx_enable});

		// bad crc on a request
		send_frame(32'h1CE1CEBB, body, 16'h0001);
		idle_cycles(3 * byte_cycles);
		check_value("tx bytes after bad request", 32'h0, tx_bytes.size());

		// second request lands while the first reply is going out
		new_telemetry();
		body.delete();
		push_be(body, {24'h0, id}, 1);
		send_frame(32'h1CE1CEBB, body, 16'h0);
		wait_tx_enable(1'b1, "reply start");
		send_frame(32'h1CE1CEBB, body, 16'h0);
		wait_tx_count(reply_len, "overlapped reply");
		wait_tx_enable(1'b0, "overlapped reply end");
		idle_cycles(3 * byte_cycles);
		check_reply("overlapped reply");

		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
			other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* motor_coms.f */
common/uart_pkg.sv
common/frame_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/frame_receiver.sv
verilog/status_sender.sv
verilog/motor_coms.sv
verification/motor_coms_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = motor_coms_tb
FILELIST = motor_coms.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
